/* core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

   // Datapath
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [XLEN-1:0] addr_t;

   // Fetch
   localparam addr_t RESET_PC = '0;
   localparam addr_t PC_STEP  = 32'd4;

   // One count per data bit
   localparam int CNT_W = 5;

   typedef logic [CNT_W-1:0] cnt_t;

   // Register file
   localparam int REG_AW = 5;

   typedef logic [REG_AW-1:0] reg_addr_t;

endpackage

`default_nettype wire

/* instr_decode.sv */
`default_nettype none
`timescale 1ns/10ps

module instr_decode import core_cfg_pkg::*, rv_isa_pkg::*; (
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire word_t i_ibus_rdt,
   input  wire        i_ibus_ack,
   input  wire        i_cnt_en,
   output exec_ctrl_t o_ctrl,
   output logic       o_imm_bit
);

   instr_u      rdt_u;
   instr_u      instr_q;
   logic [11:0] imm_q;
   logic        is_op;
   logic        is_imm;
   logic [2:0]  f3;
   logic        f3_ok;
   logic        f7_ok;
   logic        legal;

   assign rdt_u = i_ibus_rdt;

   // Cleared to opcode zero, which writes nothing
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         instr_q <= '0;
      end else if (i_ibus_ack) begin
         instr_q <= rdt_u;
      end
   end

   // Immediate leaves LSB first, then the sign repeats
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= rdt_u.i_view.imm12;
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[11], imm_q[11:1]};
      end
   end

   assign o_imm_bit = imm_q[0];

   assign is_op  = instr_q.r_view.opcode == OPC_OP;
   assign is_imm = instr_q.i_view.opcode == OPC_OP_IMM;
   assign f3     = instr_q.i_view.funct3;

   // Only funct7 zero, or the SUB bit alone on ADD
   assign f7_ok = (instr_q.r_view.funct7 & ~(7'd1 << F7_SUB_BIT)) == '0 &&
                  (!instr_q.r_view.funct7[F7_SUB_BIT] || f3 == F3_ADD);
   assign legal = f3_ok && (is_imm || (is_op && f7_ok));

   always_comb begin
      o_ctrl            = '0;
      o_ctrl.rd         = instr_q.i_view.rd;
      o_ctrl.rs1        = instr_q.i_view.rs1;
      o_ctrl.rs2        = is_op ? instr_q.r_view.rs2 : '0;
      o_ctrl.use_imm    = is_imm;
      o_ctrl.sub        = is_op && f3 == F3_ADD && instr_q.r_view.funct7[F7_SUB_BIT];
      o_ctrl.cmp_signed = f3 == F3_SLT;
      o_ctrl.alu_op     = ALU_SUM;
      o_ctrl.bool_op    = BOOL_XOR;
      f3_ok             = 1'b1;
      case (f3)
         F3_ADD: begin
            o_ctrl.alu_op = ALU_SUM;
         end
         F3_SLT, F3_SLTU: begin
            o_ctrl.alu_op = ALU_CMP;
         end
         F3_XOR, F3_OR, F3_AND: begin
            o_ctrl.alu_op  = ALU_BOOL;
            o_ctrl.bool_op = bool_op_e'(f3[1:0]);
         end
         // Shift encodings are not kept
         default: begin
            f3_ok = 1'b0;
         end
      endcase
      o_ctrl.two_stage = legal && o_ctrl.alu_op == ALU_CMP;
      o_ctrl.rd_wen    = legal && instr_q.i_view.rd != '0;
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the serial_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_core \
   -f serial_core.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_serial_core > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;
   import core_cfg_pkg::*;

   // Kept opcode groups
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // Bit 30 of the word
   localparam int F7_SUB_BIT = 5;

   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } r_view_t;

   typedef struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } i_view_t;

   typedef union packed {
      r_view_t r_view;
      i_view_t i_view;
   } instr_u;

   typedef enum logic [1:0] {
      ALU_SUM  = 2'd0,
      ALU_BOOL = 2'd1,
      ALU_CMP  = 2'd2
   } alu_op_e;

   // Same as funct3[1:0] of the boolean ops
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } bool_op_e;

   typedef struct packed {
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      use_imm;
      logic      sub;
      logic      cmp_signed;
      alu_op_e   alu_op;
      bool_op_e  bool_op;
      logic      two_stage;
      logic      rd_wen;
   } exec_ctrl_t;

   typedef struct packed {
      reg_addr_t rreg0;
      reg_addr_t rreg1;
      reg_addr_t wreg;
      logic      wen;
      logic      wdata;
   } rf_port_t;

endpackage

`default_nettype wire

/* serial_alu.sv */
`default_nettype none
`timescale 1ns/10ps

module serial_alu import core_cfg_pkg::*, rv_isa_pkg::*; (
   input  wire             clk,
   input  wire             i_rst_n,
   input  wire exec_ctrl_t i_ctrl,
   input  wire             i_cnt_en,
   input  wire cnt_t       i_cnt,
   input  wire             i_pass2,
   input  wire             i_rs1_bit,
   input  wire             i_rs2_bit,
   input  wire             i_imm_bit,
   output logic            o_rd_bit
);

   logic do_sub;
   logic op_b_raw;
   logic op_b;
   logic carry_in;
   logic carry_out;
   logic sum;
   logic bool_bit;
   logic lt;
   logic carry_q;
   logic cmp_q;

   // Compare runs as a subtraction
   assign do_sub   = i_ctrl.sub || i_ctrl.alu_op == ALU_CMP;
   assign op_b_raw = i_ctrl.use_imm ? i_imm_bit : i_rs2_bit;
   assign op_b     = op_b_raw ^ do_sub;

   assign carry_in  = (i_cnt == '0) ? do_sub : carry_q;
   assign sum       = i_rs1_bit ^ op_b ^ carry_in;
   assign carry_out = (i_rs1_bit & op_b) | (carry_in & (i_rs1_bit ^ op_b));

   // Sign bits decide when they differ, otherwise the borrow
   assign lt = (i_rs1_bit ^ op_b_raw) ? (i_ctrl.cmp_signed ? i_rs1_bit : op_b_raw)
                                      : !carry_out;

   always_comb begin
      case (i_ctrl.bool_op)
         BOOL_OR:  bool_bit = i_rs1_bit | op_b_raw;
         BOOL_AND: bool_bit = i_rs1_bit & op_b_raw;
         default:  bool_bit = i_rs1_bit ^ op_b_raw;
      endcase
   end

   // Write pass leaves carry and compare alone
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         cmp_q   <= 1'b0;
      end else if (i_cnt_en && !i_pass2) begin
         carry_q <= carry_out;
         if (i_cnt == '1) begin
            cmp_q <= lt;
         end
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_BOOL: o_rd_bit = bool_bit;
         ALU_CMP:  o_rd_bit = i_pass2 && i_cnt == '0 && cmp_q;
         default:  o_rd_bit = sum;
      endcase
   end

endmodule

`default_nettype wire

/* serial_core.f */
core_cfg_pkg.sv
rv_isa_pkg.sv
serial_fetch.sv
instr_decode.sv
serial_state.sv
serial_alu.sv
serial_core.sv
tb_clock_gen.sv
tb_serial_core.sv

/* serial_core.sv */
`default_nettype none
`timescale 1ns/10ps

module serial_core import core_cfg_pkg::*, rv_isa_pkg::*; (
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire word_t i_ibus_rdt,
   input  wire        i_ibus_ack,
   input  wire        i_rf_ready,
   input  wire        i_rdata0,
   input  wire        i_rdata1,
   output addr_t      o_ibus_adr,
   output logic       o_ibus_cyc,
   output logic       o_rf_rreq,
   output rf_port_t   o_rf
);

   exec_ctrl_t ctrl;
   logic       fetch_req;
   logic       cnt_en;
   cnt_t       cnt;
   logic       pass2;
   logic       wen;
   logic       imm_bit;
   logic       rd_bit;

   serial_fetch fetch_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_fetch_req (fetch_req),
      .i_ibus_ack  (i_ibus_ack),
      .o_ibus_adr  (o_ibus_adr),
      .o_ibus_cyc  (o_ibus_cyc)
   );

   instr_decode decode_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt_en   (cnt_en),
      .o_ctrl     (ctrl),
      .o_imm_bit  (imm_bit)
   );

   serial_state state_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ctrl      (ctrl),
      .i_ibus_ack  (i_ibus_ack),
      .i_rf_ready  (i_rf_ready),
      .o_fetch_req (fetch_req),
      .o_rf_rreq   (o_rf_rreq),
      .o_cnt_en    (cnt_en),
      .o_cnt       (cnt),
      .o_pass2     (pass2),
      .o_wen       (wen)
   );

   serial_alu alu_inst (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_ctrl    (ctrl),
      .i_cnt_en  (cnt_en),
      .i_cnt     (cnt),
      .i_pass2   (pass2),
      .i_rs1_bit (i_rdata0),
      .i_rs2_bit (i_rdata1),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (rd_bit)
   );

   assign o_rf = '{rreg0: ctrl.rs1, rreg1: ctrl.rs2, wreg: ctrl.rd, wen: wen, wdata: rd_bit};

endmodule

`default_nettype wire

/* serial_fetch.sv */
`default_nettype none
`timescale 1ns/10ps

module serial_fetch import core_cfg_pkg::*; (
   input  wire   clk,
   input  wire   i_rst_n,
   input  wire   i_fetch_req,
   input  wire   i_ibus_ack,
   output addr_t o_ibus_adr,
   output logic  o_ibus_cyc
);

   addr_t pc_q;
   logic  cyc_q;

   // Reset itself launches the first fetch at RESET_PC
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q  <= RESET_PC;
         cyc_q <= 1'b1;
      end else begin
         if (i_fetch_req) begin
            pc_q <= pc_q + PC_STEP;
         end
         if (i_fetch_req) begin
            cyc_q <= 1'b1;
         end else if (i_ibus_ack) begin
            cyc_q <= 1'b0;
         end
      end
   end

   assign o_ibus_adr = pc_q;
   assign o_ibus_cyc = cyc_q;

   // Request held with a steady address until the slave acks
   a_cyc_until_ack: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc && $stable(o_ibus_adr)
   );

   // No new request while one is still open
   a_req_when_idle: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_fetch_req |-> !o_ibus_cyc
   );

endmodule

`default_nettype wire

/* serial_state.sv */
`default_nettype none
`timescale 1ns/10ps

module serial_state import core_cfg_pkg::*, rv_isa_pkg::*; (
   input  wire             clk,
   input  wire             i_rst_n,
   input  wire exec_ctrl_t i_ctrl,
   input  wire             i_ibus_ack,
   input  wire             i_rf_ready,
   output logic            o_fetch_req,
   output logic            o_rf_rreq,
   output logic            o_cnt_en,
   output cnt_t            o_cnt,
   output logic            o_pass2,
   output logic            o_wen
);

   typedef enum logic [2:0] {
      PH_FETCH,
      PH_REQ,
      PH_WAIT,
      PH_RUN,
      PH_PASS2
   } phase_e;

   phase_e phase_q;
   cnt_t   cnt_q;
   logic   last_bit;

   assign o_cnt_en = phase_q == PH_RUN || phase_q == PH_PASS2;
   assign last_bit = o_cnt_en && cnt_q == '1;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         phase_q <= PH_FETCH;
         cnt_q   <= '0;
      end else begin
         // Wraps back to zero after bit 31
         if (o_cnt_en) begin
            cnt_q <= cnt_q + 1'b1;
         end
         case (phase_q)
            PH_FETCH: if (i_ibus_ack) phase_q <= PH_REQ;
            PH_REQ:   phase_q <= PH_WAIT;
            PH_WAIT:  if (i_rf_ready) phase_q <= PH_RUN;
            PH_RUN: begin
               if (last_bit) begin
                  phase_q <= i_ctrl.two_stage ? PH_PASS2 : PH_FETCH;
               end
            end
            PH_PASS2: if (last_bit) phase_q <= PH_FETCH;
            default:  phase_q <= PH_FETCH;
         endcase
      end
   end

   assign o_fetch_req = last_bit && (phase_q == PH_PASS2 || !i_ctrl.two_stage);
   assign o_rf_rreq   = phase_q == PH_REQ;
   assign o_cnt       = cnt_q;
   assign o_pass2     = phase_q == PH_PASS2;

   // Compare results are written in the second pass only
   assign o_wen = i_ctrl.rd_wen &&
                  ((phase_q == PH_RUN && !i_ctrl.two_stage) || phase_q == PH_PASS2);

   // x0 is never written
   a_no_x0_write: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_wen |-> i_ctrl.rd != '0
   );

   // Counter back at bit 0 whenever the core waits for a fetch
   a_fetch_idle: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      phase_q == PH_FETCH |-> cnt_q == '0
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic o_rst_n
);

   localparam int RESET_CYCLES = 5;

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      o_rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* tb_serial_core.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_serial_core import core_cfg_pkg::*, rv_isa_pkg::*; ();

   localparam word_t SEED          = 32'hc97d1567;
   localparam int    NUM_INSTR     = 400;
   localparam int    FETCH_TIMEOUT = 100;
   localparam int    REQ_TIMEOUT   = 10;

   logic     clk;
   logic     rst_n;
   word_t    ibus_rdt;
   logic     ibus_ack;
   logic     rf_ready;
   logic     rdata0;
   logic     rdata1;
   addr_t    ibus_adr;
   logic     ibus_cyc;
   logic     rf_rreq;
   rf_port_t rf_port;

   word_t     rng_state;
   word_t     rf_mem [32];
   word_t     ref_regs [32];
   word_t     wr_word;
   reg_addr_t wr_reg;
   int        wr_idx;
   addr_t     exp_pc;

   tb_clock_gen clock_gen_inst (
      .clk     (clk),
      .o_rst_n (rst_n)
   );

   serial_core serial_core_inst (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_rf_ready (rf_ready),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_rf       (rf_port)
   );

   function automatic word_t xorshift32(input word_t s);
      word_t x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic word_t next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic stop_with_failure();
      $display("** FAIL **");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED: %s expected %b actual %b", name, exp, act);
         stop_with_failure();
      end
   endtask

   // Mostly kept ops, some shift funct3, bad funct7 and foreign opcodes
   function automatic word_t make_instr();
      word_t      r;
      word_t      f;
      logic [6:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      logic [4:0] rd;
      r = next_rand();
      f = next_rand();
      case (r[6:4])
         3'd0:    f3 = F3_ADD;
         3'd1:    f3 = F3_SLT;
         3'd2:    f3 = F3_SLTU;
         3'd3:    f3 = F3_XOR;
         3'd4:    f3 = F3_OR;
         3'd5:    f3 = F3_AND;
         default: f3 = r[9:7];
      endcase
      if (r[3:0] == 4'd0) begin
         opc = f[6:0];
         if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            opc = 7'b0000011;
         end
      end else begin
         opc = r[3] ? OPC_OP_IMM : OPC_OP;
      end
      f7 = (f3 == F3_ADD && r[10]) ? 7'h20 : 7'h00;
      if (r[20:16] == '0) begin
         f7 = f[31:25];
      end
      rd = (r[13:11] == '0) ? 5'd0 : f[11:7];
      if (opc == OPC_OP_IMM) begin
         return {f[31:20], f[19:15], f3, rd, opc};
      end
      return {f7, f[24:20], f[19:15], f3, rd, opc};
   endfunction

   // Architectural result of one instruction on the reference registers
   task automatic apply_model(input word_t instr);
      logic [6:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      logic [4:0] rd;
      word_t      a;
      word_t      b;
      word_t      res;
      logic       legal;
      opc   = instr[6:0];
      rd    = instr[11:7];
      f3    = instr[14:12];
      f7    = instr[31:25];
      a     = ref_regs[instr[19:15]];
      b     = (opc == OPC_OP_IMM) ? {{20{instr[31]}}, instr[31:20]} : ref_regs[instr[24:20]];
      legal = opc == OPC_OP_IMM ||
              (opc == OPC_OP && (f7 == 7'h00 || (f7 == 7'h20 && f3 == F3_ADD)));
      res   = '0;
      case (f3)
         F3_ADD:  res = (opc == OPC_OP && f7[5]) ? a - b : a + b;
         F3_SLT:  res = {31'd0, $signed(a) < $signed(b)};
         F3_SLTU: res = {31'd0, a < b};
         F3_XOR:  res = a ^ b;
         F3_OR:   res = a | b;
         F3_AND:  res = a & b;
         default: legal = 1'b0;
      endcase
      if (legal && rd != 5'd0) begin
         ref_regs[rd] = res;
      end
   endtask

   task automatic wait_for_rreq();
      int n;
      n = 0;
      @(negedge clk);
      while (!rf_rreq && n < REQ_TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      if (!rf_rreq) begin
         $display("Timeout: no register file request after the instruction fetch");
         stop_with_failure();
      end
   endtask

   task automatic wait_for_fetch();
      int n;
      n = 0;
      @(negedge clk);
      while (!ibus_cyc && n < FETCH_TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      if (!ibus_cyc) begin
         $display("Timeout: the core never started the next instruction fetch");
         stop_with_failure();
      end
   endtask

   // Called at a negedge with the fetch open
   task automatic run_instr(input int n);
      word_t instr;
      word_t r;
      word_t op_a;
      word_t op_b;
      int    k;
      check_addr($sformatf("fetch address of instruction %0d", n), exp_pc, ibus_adr);
      instr = make_instr();
      r     = next_rand();
      @(posedge clk);
      repeat (int'(r[1:0])) @(posedge clk);
      ibus_ack <= 1'b1;
      ibus_rdt <= instr;
      @(posedge clk);
      ibus_ack <= 1'b0;
      ibus_rdt <= next_rand();
      wait_for_rreq();
      check_bit($sformatf("cyc after ack of instruction %0d", n), 1'b0, ibus_cyc);
      op_a = rf_mem[rf_port.rreg0];
      op_b = rf_mem[rf_port.rreg1];
      @(posedge clk);
      repeat (int'(r[3:2])) @(posedge clk);
      rf_ready <= 1'b1;
      @(posedge clk);
      rf_ready <= 1'b0;
      for (k = 0; k < XLEN; k++) begin
         rdata0 <= op_a[k];
         rdata1 <= op_b[k];
         @(posedge clk);
      end
      rdata0 <= 1'b0;
      rdata1 <= 1'b0;
      apply_model(instr);
      wait_for_fetch();
      exp_pc = exp_pc + PC_STEP;
      check_bit($sformatf("wen at fetch %0d", n + 1), 1'b0, rf_port.wen);
      if (wr_idx != 0) begin
         $display("Register write of instruction %0d stopped after %0d bits", n, wr_idx);
         stop_with_failure();
      end else begin
         for (k = 0; k < 32; k++) begin
            check_word($sformatf("x%0d after instruction %0d (%h)", k, n, instr),
                       ref_regs[k], rf_mem[k]);
         end
      end
   endtask

   // Register file write side, one bit per cycle from bit 0
   always @(negedge clk) begin
      if (rst_n && rf_port.wen) begin
         if (wr_idx != 0 && rf_port.wreg != wr_reg) begin
            $display("Write register changed in the middle of a register write");
            stop_with_failure();
         end else begin
            wr_reg          = rf_port.wreg;
            wr_word[wr_idx] = rf_port.wdata;
            wr_idx          = wr_idx + 1;
            if (wr_idx == XLEN) begin
               rf_mem[wr_reg] = wr_word;
               wr_idx         = 0;
            end
         end
      end
   end

   initial begin
      int n;
      int i;
      ibus_rdt  = '0;
      ibus_ack  = 1'b0;
      rf_ready  = 1'b0;
      rdata0    = 1'b0;
      rdata1    = 1'b0;
      wr_word   = '0;
      wr_reg    = '0;
      wr_idx    = 0;
      exp_pc    = RESET_PC;
      rng_state = SEED;
      for (i = 0; i < 32; i++) begin
         rf_mem[i]   = (i == 0) ? '0 : next_rand();
         ref_regs[i] = rf_mem[i];
      end
      n = 0;
      while (!rst_n && n < 20) begin
         n++;
         @(posedge clk);
      end
      if (!rst_n) begin
         $display("Reset was never released");
         stop_with_failure();
      end
      @(negedge clk);
      check_bit("cyc after reset", 1'b1, ibus_cyc);
      check_addr("first fetch address", RESET_PC, ibus_adr);
      check_bit("rreq after reset", 1'b0, rf_rreq);
      check_bit("wen after reset", 1'b0, rf_port.wen);
      for (n = 0; n < NUM_INSTR; n++) begin
         run_instr(n);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire
